// ==== include/vlsu_cfg.svh ====
// sizing of the vector load/store unit and its memory banks
// include wherever the bank geometry or the group size is needed

`ifndef VLSU_CFG_SVH
`define VLSU_CFG_SVH

// four banks, one word each per beat
`define VLSU_NUM_BANKS  4

// bits per bank word
`define VLSU_BANK_WIDTH 32

// bank word address
`define VLSU_ADDR_WIDTH 12

// beats in a full register group (lmul 4)
`define VLSU_MAX_BEATS  4

`endif

// ==== verilog/vlsu_pkg.sv ====
// shared types of the vector load/store unit
// referenced by scoped name from every module of the unit

`default_nettype none

`include "vlsu_cfg.svh"

package vlsu_pkg;

    typedef logic [`VLSU_BANK_WIDTH-1:0] bank_word_t;
    typedef logic [`VLSU_ADDR_WIDTH-1:0] bank_addr_t;

    // lane i sits in element [i]
    typedef bank_word_t [`VLSU_NUM_BANKS-1:0] lane_word_vec_t;
    typedef bank_addr_t [`VLSU_NUM_BANKS-1:0] lane_addr_vec_t;

    typedef logic [`VLSU_NUM_BANKS*`VLSU_BANK_WIDTH-1:0] beat_t;
    typedef logic [`VLSU_MAX_BEATS*`VLSU_NUM_BANKS*`VLSU_BANK_WIDTH-1:0] vreg_group_t;
    typedef logic [2:0] beat_idx_t;

    typedef enum logic {
        VLSU_LOAD  = 1'b0,
        VLSU_STORE = 1'b1
    } vlsu_op_e;

    // other codes behave as LMUL_1
    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010
    } lmul_e;

endpackage

`default_nettype wire

// ==== verilog/vlsu_ctrl.sv ====
// command FSM of the vector load/store unit
// issues one bank beat per transfer and tracks the read in flight for the gatherer

`timescale 1ns/100ps
`default_nettype none

`include "vlsu_cfg.svh"

module vlsu_ctrl (
    input  wire                            clk,
    input  wire                            nrst,
    input  wire                            cmd_valid,
    input  wire vlsu_pkg::vlsu_op_e        cmd_op,
    input  wire vlsu_pkg::lmul_e           cmd_lmul,
    input  wire vlsu_pkg::bank_addr_t      cmd_addr,
    input  wire                            mem_ready,
    input  wire                            rsp_ready,
    output logic                           cmd_ready,
    output logic                           cmd_accept,
    output logic                           mem_valid,
    output logic                           mem_write,
    output vlsu_pkg::lane_addr_vec_t       mem_addr,
    output vlsu_pkg::beat_idx_t            beat_idx,
    output logic                           beat_capture,
    output vlsu_pkg::beat_idx_t            capture_idx,
    output logic                           rsp_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_DRAIN,
        ST_RESPOND
    } state_e;

    state_e                 state_q;
    vlsu_pkg::vlsu_op_e     op_q;
    vlsu_pkg::bank_addr_t   base_q;
    vlsu_pkg::beat_idx_t    beats_q;
    vlsu_pkg::beat_idx_t    beat_q;
    vlsu_pkg::beat_idx_t    cmd_beats;
    logic                   beat_fire;
    logic                   last_beat;
    logic                   rd_pending_q;
    vlsu_pkg::beat_idx_t    rd_idx_q;

    always_comb begin
        case (cmd_lmul)
            vlsu_pkg::LMUL_2: cmd_beats = 3'd2;
            vlsu_pkg::LMUL_4: cmd_beats = vlsu_pkg::beat_idx_t'(`VLSU_MAX_BEATS);
            default:          cmd_beats = 3'd1;
        endcase
    end

    assign cmd_ready  = (state_q == ST_IDLE);
    assign cmd_accept = cmd_valid && cmd_ready;
    assign mem_valid  = (state_q == ST_ISSUE);
    assign mem_write  = mem_valid && (op_q == vlsu_pkg::VLSU_STORE);
    assign rsp_valid  = (state_q == ST_RESPOND);
    assign beat_fire  = mem_valid && mem_ready;
    assign last_beat  = (vlsu_pkg::beat_idx_t'(beat_q + 3'd1) == beats_q);

    assign beat_idx     = beat_q;
    assign beat_capture = rd_pending_q;
    assign capture_idx  = rd_idx_q;

    // unit stride, lane i of beat b at base + 4b + i
    always_comb begin
        for (int i = 0; i < `VLSU_NUM_BANKS; i++) begin
            mem_addr[i] = base_q
                        + vlsu_pkg::bank_addr_t'(beat_q)
                        * vlsu_pkg::bank_addr_t'(`VLSU_NUM_BANKS)
                        + vlsu_pkg::bank_addr_t'(i);
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= ST_IDLE;
            op_q    <= vlsu_pkg::VLSU_LOAD;
            base_q  <= '0;
            beats_q <= 3'd1;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cmd_accept) begin
                        op_q    <= cmd_op;
                        base_q  <= cmd_addr;
                        beats_q <= cmd_beats;
                        beat_q  <= '0;
                        state_q <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (beat_fire) begin
                        if (last_beat) begin
                            // back to beat 0 so the slicer never indexes past the group
                            beat_q  <= '0;
                            state_q <= (op_q == vlsu_pkg::VLSU_STORE) ? ST_RESPOND : ST_DRAIN;
                        end else begin
                            beat_q <= beat_q + 3'd1;
                        end
                    end
                end
                ST_DRAIN: begin
                    // last read data is captured this cycle
                    if (rd_pending_q) begin
                        state_q <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (rsp_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // one read in flight, data due the cycle after acceptance
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_pending_q <= 1'b0;
            rd_idx_q     <= '0;
        end else begin
            rd_pending_q <= beat_fire && !mem_write;
            if (beat_fire) begin
                rd_idx_q <= beat_q;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vlsu_store_slicer.sv ====
// store data path of the vector load/store unit
// keeps the register group from the accepted command and puts one beat on the bank lanes

`timescale 1ns/100ps
`default_nettype none

module vlsu_store_slicer (
    input  wire                            clk,
    input  wire                            nrst,
    input  wire                            cmd_accept,
    input  wire vlsu_pkg::vreg_group_t     cmd_wdata,
    input  wire vlsu_pkg::beat_idx_t       beat_idx,
    output vlsu_pkg::lane_word_vec_t       mem_wdata
);

    localparam int BEAT_W = $bits(vlsu_pkg::beat_t);

    vlsu_pkg::vreg_group_t  group_q;
    vlsu_pkg::beat_t        beat_sel;

    // loads capture too, the controller's mem_write ignores it then
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            group_q <= '0;
        end else if (cmd_accept) begin
            group_q <= cmd_wdata;
        end
    end

    // beat b is bits [128b, +128)
    assign beat_sel = group_q[beat_idx * BEAT_W +: BEAT_W];

    // lane i takes bits [32i, +32) of the beat
    assign mem_wdata = vlsu_pkg::lane_word_vec_t'(beat_sel);

endmodule

`default_nettype wire

// ==== verilog/vlsu_load_gather.sv ====
// load result register of the vector load/store unit
// cleared on every accepted command, then filled one beat per capture pulse

`timescale 1ns/100ps
`default_nettype none

module vlsu_load_gather (
    input  wire                            clk,
    input  wire                            nrst,
    input  wire                            cmd_accept,
    input  wire                            beat_capture,
    input  wire vlsu_pkg::beat_idx_t       capture_idx,
    input  wire vlsu_pkg::lane_word_vec_t  mem_rdata,
    output vlsu_pkg::vreg_group_t          rsp_data
);

    localparam int BEAT_W = $bits(vlsu_pkg::beat_t);

    vlsu_pkg::beat_t    beat_in;

    // lane 0 lands in the low word of the beat
    assign beat_in = vlsu_pkg::beat_t'(mem_rdata);

    // beats never filled stay zero, which covers short groups and stores
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rsp_data <= '0;
        end else if (cmd_accept) begin
            rsp_data <= '0;
        end else if (beat_capture) begin
            rsp_data[capture_idx * BEAT_W +: BEAT_W] <= beat_in;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vlsu_top.sv ====
// unit-stride vector load/store unit over four 32-bit memory banks
// valid/ready on command, bank request and response; read data one cycle after a read beat

`timescale 1ns/100ps
`default_nettype none

module vlsu_top (
    input  wire                            clk,
    input  wire                            nrst,
    input  wire                            cmd_valid,
    output logic                           cmd_ready,
    input  wire vlsu_pkg::vlsu_op_e        cmd_op,
    input  wire vlsu_pkg::lmul_e           cmd_lmul,
    input  wire vlsu_pkg::bank_addr_t      cmd_addr,
    input  wire vlsu_pkg::vreg_group_t     cmd_wdata,
    output logic                           mem_valid,
    input  wire                            mem_ready,
    output logic                           mem_write,
    output vlsu_pkg::lane_addr_vec_t       mem_addr,
    output vlsu_pkg::lane_word_vec_t       mem_wdata,
    input  wire vlsu_pkg::lane_word_vec_t  mem_rdata,
    output logic                           rsp_valid,
    input  wire                            rsp_ready,
    output vlsu_pkg::vreg_group_t          rsp_data
);

    logic                   cmd_accept;
    vlsu_pkg::beat_idx_t    beat_idx;
    logic                   beat_capture;
    vlsu_pkg::beat_idx_t    capture_idx;

    vlsu_ctrl i_ctrl (
        .clk          (clk),
        .nrst         (nrst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_lmul     (cmd_lmul),
        .cmd_addr     (cmd_addr),
        .mem_ready    (mem_ready),
        .rsp_ready    (rsp_ready),
        .cmd_ready    (cmd_ready),
        .cmd_accept   (cmd_accept),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .beat_idx     (beat_idx),
        .beat_capture (beat_capture),
        .capture_idx  (capture_idx),
        .rsp_valid    (rsp_valid)
    );

    vlsu_store_slicer i_slicer (
        .clk        (clk),
        .nrst       (nrst),
        .cmd_accept (cmd_accept),
        .cmd_wdata  (cmd_wdata),
        .beat_idx   (beat_idx),
        .mem_wdata  (mem_wdata)
    );

    vlsu_load_gather i_gather (
        .clk          (clk),
        .nrst         (nrst),
        .cmd_accept   (cmd_accept),
        .beat_capture (beat_capture),
        .capture_idx  (capture_idx),
        .mem_rdata    (mem_rdata),
        .rsp_data     (rsp_data)
    );

endmodule

`default_nettype wire

// ==== tests/vlsu_assert.sv ====
// protocol checks for the vector load/store unit, bound into vlsu_top
// requests hold under back-pressure, responses hold, the unit stays busy while it works

`timescale 1ns/100ps
`default_nettype none

module vlsu_assert (
    input wire                            clk,
    input wire                            nrst,
    input wire                            cmd_valid,
    input wire                            cmd_ready,
    input wire vlsu_pkg::vlsu_op_e        cmd_op,
    input wire                            mem_valid,
    input wire                            mem_ready,
    input wire                            mem_write,
    input wire vlsu_pkg::lane_addr_vec_t  mem_addr,
    input wire vlsu_pkg::lane_word_vec_t  mem_wdata,
    input wire                            rsp_valid,
    input wire                            rsp_ready
);

    vlsu_pkg::vlsu_op_e  op_q;
    bit                  hold_fail  = 1'b0;
    bit                  rsp_fail   = 1'b0;
    bit                  busy_fail  = 1'b0;
    bit                  write_fail = 1'b0;
    wire                 any_fail;

    // operation of the command in progress
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            op_q <= vlsu_pkg::VLSU_LOAD;
        end else if (cmd_valid && cmd_ready) begin
            op_q <= cmd_op;
        end
    end

    assign any_fail = hold_fail | rsp_fail | busy_fail | write_fail;

    req_hold: assert property (@(posedge clk) disable iff (!nrst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write)
                                    && $stable(mem_addr) && $stable(mem_wdata))
        else begin
            hold_fail = 1'b1;
            $error("bank request changed while mem_ready was low");
        end

    rsp_hold: assert property (@(posedge clk) disable iff (!nrst)
        rsp_valid && !rsp_ready |=> rsp_valid)
        else begin
            rsp_fail = 1'b1;
            $error("rsp_valid dropped before rsp_ready");
        end

    busy_no_ready: assert property (@(posedge clk) disable iff (!nrst)
        mem_valid || rsp_valid |-> !cmd_ready)
        else begin
            busy_fail = 1'b1;
            $error("cmd_ready high while the unit is busy");
        end

    load_no_write: assert property (@(posedge clk) disable iff (!nrst)
        mem_valid && op_q == vlsu_pkg::VLSU_LOAD |-> !mem_write)
        else begin
            write_fail = 1'b1;
            $error("mem_write high during a load");
        end

endmodule

bind vlsu_top vlsu_assert i_vlsu_assert (
    .clk       (clk),
    .nrst      (nrst),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
);

`default_nettype wire

// ==== tests/tb_vlsu.sv ====
// testbench for the vector load/store unit
// runs stores and loads of every lmul code against a bank memory model and a reference memory

`timescale 1ns/100ps
`default_nettype none

`include "vlsu_cfg.svh"

module tb_vlsu;

    localparam int NUM_CMDS  = 40;
    localparam int MEM_WORDS = 1 << `VLSU_ADDR_WIDTH;
    localparam int BANK_W    = `VLSU_BANK_WIDTH;
    localparam int BEAT_W    = `VLSU_NUM_BANKS * `VLSU_BANK_WIDTH;

    logic                      clk = 1'b0;
    logic                      nrst;
    logic                      cmd_valid;
    logic                      cmd_ready;
    vlsu_pkg::vlsu_op_e        cmd_op;
    vlsu_pkg::lmul_e           cmd_lmul;
    vlsu_pkg::bank_addr_t      cmd_addr;
    vlsu_pkg::vreg_group_t     cmd_wdata;
    logic                      mem_valid;
    logic                      mem_ready;
    logic                      mem_write;
    vlsu_pkg::lane_addr_vec_t  mem_addr;
    vlsu_pkg::lane_word_vec_t  mem_wdata;
    vlsu_pkg::lane_word_vec_t  mem_rdata;
    logic                      rsp_valid;
    logic                      rsp_ready;
    vlsu_pkg::vreg_group_t     rsp_data;

    vlsu_pkg::bank_word_t      bank_mem [MEM_WORDS];
    vlsu_pkg::bank_word_t      ref_mem [MEM_WORDS];
    vlsu_pkg::vlsu_op_e        cur_op;
    vlsu_pkg::bank_addr_t      cur_addr;
    vlsu_pkg::vreg_group_t     cur_wdata;
    int                        cur_beats;
    int                        cur_base_count;
    int                        beat_count;
    int                        cycle = 0;
    logic                      random_stalls;

    vlsu_top i_vlsu_top (
        .clk       (clk),
        .nrst      (nrst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_lmul  (cmd_lmul),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    // odd multiplier keeps every address distinct
    function automatic vlsu_pkg::bank_word_t fill_word(input int a);
        return 32'hA5C3_0F00 ^ (32'(a) * 32'h9E37_79B9);
    endfunction

    function automatic int beats_for(input logic [2:0] code);
        if (code == vlsu_pkg::LMUL_2) begin
            return 2;
        end
        if (code == vlsu_pkg::LMUL_4) begin
            return 4;
        end
        return 1;
    endfunction

    function automatic vlsu_pkg::bank_addr_t lane_addr(input vlsu_pkg::bank_addr_t base,
                                                       input int b, input int i);
        return vlsu_pkg::bank_addr_t'(int'(base) + `VLSU_NUM_BANKS * b + i);
    endfunction

    // bank memory returns read data one cycle after each accepted read beat
    initial begin
        logic                      rd_fire;
        vlsu_pkg::lane_addr_vec_t  rd_addr;
        int                        b;
        for (int a = 0; a < MEM_WORDS; a++) begin
            bank_mem[a] = fill_word(a);
        end
        beat_count = 0;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(posedge clk);
            rd_fire = mem_valid && mem_ready && !mem_write;
            rd_addr = mem_addr;
            if (mem_valid && mem_ready) begin
                b = beat_count - cur_base_count;
                assert (b < cur_beats) else fail_check("more beats than the group holds");
                assert (mem_write == (cur_op == vlsu_pkg::VLSU_STORE))
                    else fail_check("mem_write does not match the operation");
                for (int i = 0; i < `VLSU_NUM_BANKS; i++) begin
                    assert (mem_addr[i] == lane_addr(cur_addr, b, i))
                        else fail_check("bank lane address mismatch");
                    if (mem_write) begin
                        assert (mem_wdata[i] == cur_wdata[b * BEAT_W + i * BANK_W +: BANK_W])
                            else fail_check("bank lane write data mismatch");
                        bank_mem[mem_addr[i]] = mem_wdata[i];
                    end
                end
                beat_count++;
            end
            #1;
            // junk on the read lanes when nothing is due
            for (int i = 0; i < `VLSU_NUM_BANKS; i++) begin
                mem_rdata[i] = rd_fire ? bank_mem[rd_addr[i]] : $urandom();
            end
            mem_ready = random_stalls ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    task automatic run_cmd(input vlsu_pkg::vlsu_op_e op, input logic [2:0] code,
                           input vlsu_pkg::bank_addr_t addr, input bit timed);
        vlsu_pkg::vreg_group_t  wdata;
        vlsu_pkg::vreg_group_t  expect_data;
        vlsu_pkg::vreg_group_t  got;
        int                     n;
        int                     t_accept;
        int                     t_rsp;
        n = beats_for(code);
        for (int w = 0; w < $bits(wdata) / BANK_W; w++) begin
            wdata[w * BANK_W +: BANK_W] = $urandom();
        end
        expect_data = '0;
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < `VLSU_NUM_BANKS; i++) begin
                if (op == vlsu_pkg::VLSU_STORE) begin
                    ref_mem[lane_addr(addr, b, i)] = wdata[b * BEAT_W + i * BANK_W +: BANK_W];
                end else begin
                    expect_data[b * BEAT_W + i * BANK_W +: BANK_W] = ref_mem[lane_addr(addr, b, i)];
                end
            end
        end
        cur_op         = op;
        cur_addr       = addr;
        cur_wdata      = wdata;
        cur_beats      = n;
        cur_base_count = beat_count;
        cmd_valid      = 1'b1;
        cmd_op         = op;
        cmd_lmul       = vlsu_pkg::lmul_e'(code);
        cmd_addr       = addr;
        cmd_wdata      = wdata;
        rsp_ready      = timed ? 1'b1 : ($urandom_range(3) != 0);
        do @(posedge clk); while (!cmd_ready);
        t_accept = cycle;
        #1;
        cmd_valid = 1'b0;
        assert (!cmd_ready) else fail_check("cmd_ready still high after accept");
        t_rsp = -1;
        forever begin
            @(posedge clk);
            assert (!cmd_ready) else fail_check("cmd_ready high before the response was taken");
            if (rsp_valid && t_rsp < 0) begin
                t_rsp = cycle;
            end
            got = rsp_data;
            if (rsp_valid && rsp_ready) begin
                break;
            end
            #1;
            if (!timed) begin
                rsp_ready = ($urandom_range(3) != 0);
            end
        end
        #1;
        assert (cmd_ready) else fail_check("cmd_ready low after the response was taken");
        assert (beat_count - cur_base_count == n) else fail_check("wrong number of beats");
        assert (got == expect_data) else fail_check("response data mismatch");
        if (timed) begin
            assert (t_rsp - t_accept == n + ((op == vlsu_pkg::VLSU_STORE) ? 1 : 2))
                else fail_check("rsp_valid latency mismatch");
        end
    endtask

    initial begin
        vlsu_pkg::bank_addr_t  addr;
        void'($urandom(42));
        nrst           = 1'b0;
        cmd_valid      = 1'b0;
        cmd_op         = vlsu_pkg::VLSU_LOAD;
        cmd_lmul       = vlsu_pkg::LMUL_1;
        cmd_addr       = '0;
        cmd_wdata      = '0;
        rsp_ready      = 1'b0;
        random_stalls  = 1'b0;
        cur_op         = vlsu_pkg::VLSU_LOAD;
        cur_addr       = '0;
        cur_wdata      = '0;
        cur_beats      = 0;
        cur_base_count = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            ref_mem[a] = fill_word(a);
        end
        repeat (5) @(posedge clk);
        #1;
        nrst = 1'b1;
        assert (cmd_ready && !mem_valid && !rsp_valid) else fail_check("unit not idle after reset");
        // each of the eight lmul codes stored and loaded back without stalls
        for (int code = 0; code < 8; code++) begin
            addr = vlsu_pkg::bank_addr_t'($urandom());
            run_cmd(vlsu_pkg::VLSU_STORE, 3'(code), addr, 1'b1);
            run_cmd(vlsu_pkg::VLSU_LOAD, 3'(code), addr, 1'b1);
        end
        // small address window so loads overlap earlier stores
        random_stalls = 1'b1;
        for (int k = 0; k < NUM_CMDS - 16; k++) begin
            run_cmd(($urandom_range(1) == 0) ? vlsu_pkg::VLSU_LOAD : vlsu_pkg::VLSU_STORE,
                    3'($urandom_range(7)), vlsu_pkg::bank_addr_t'($urandom_range(63)), 1'b0);
        end
        repeat (2) @(posedge clk);
        if (!i_vlsu_top.i_vlsu_assert.any_fail) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("a bound protocol assertion failed during the run");
            $display("Verification failed");
            $fatal(1, "protocol assertion failure");
        end
    end

    // a failed protocol assertion ends the run at once
    initial begin
        wait (i_vlsu_top.i_vlsu_assert.any_fail);
        $display("a bound protocol assertion failed at %0t ns", $time);
        $display("Verification failed");
        $fatal(1, "protocol assertion failure");
    end

    initial begin
        #(NUM_CMDS * 40 * 8);
        $display("timeout: the commands did not complete in the expected time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== vlsu_top.f ====
+incdir+include
verilog/vlsu_pkg.sv
verilog/vlsu_ctrl.sv
verilog/vlsu_store_slicer.sv
verilog/vlsu_load_gather.sv
verilog/vlsu_top.sv
tests/vlsu_assert.sv
tests/tb_vlsu.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the vlsu testbench with Verilator, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_vlsu -f vlsu_top.f -o sim_vlsu
if [ $? -ne 0 ]; then
    echo "run_sim: compile step failed"
    exit 1
fi

# keep running after an assertion error so the testbench reports it at the end
./obj_dir/sim_vlsu +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi
